//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mdu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/mdu_pkg.sv
design/mdu_operand_prep.sv
design/mdu_ctrl.sv
design/mdu_datapath.sv
design/mdu_top.sv
verif/mdu_assert.sv
verif/mdu_tb.sv

//--- design/mdu_ctrl.sv
module mdu_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  mdu_pkg::mdu_prep_t prep_i,
  output mdu_pkg::mdu_ctl_t  ctl_o,
  output logic               done_o
);
  import mdu_pkg::*;

  mdu_state_e       state_q;
  mdu_state_e       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic             is_div_q;
  logic             done_q;
  logic             accept;
  logic             exc_hit;
  logic             last_step;
  logic             stepping;

  assign accept    = (state_q == S_IDLE) & valid_i;
  assign exc_hit   = prep_i.div_by_zero | prep_i.div_overflow;
  assign last_step = (cnt_q == CNT_W'(XLEN - 1));
  assign stepping  = (state_q == S_MUL) | (state_q == S_DIV);

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          state_d = exc_hit ? S_EXC : S_LOAD;
        end
      end
      S_EXC: begin
        state_d = S_IDLE;
      end
      S_LOAD: begin
        state_d = is_div_q ? S_DIV : S_MUL;
      end
      S_MUL,
      S_DIV: begin
        if (last_step) begin
          state_d = S_FIX;
        end
      end
      S_FIX: begin
        state_d = S_DONE;
      end
      S_DONE: begin
        state_d = S_IDLE;
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // operation kind for the whole run
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_div_q <= 1'b0;
    end else if (accept) begin
      is_div_q <= prep_i.is_div;
    end
  end

  // step counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (state_q == S_LOAD) begin
      cnt_q <= '0;
    end else if (stepping) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // done one cycle after the exception or done state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= (state_q == S_EXC) | (state_q == S_DONE);
    end
  end

  // operands are taken on the accepting edge since req_i may move after
  always_comb begin
    ctl_o.load   = accept & ~exc_hit;
    ctl_o.exc    = accept & exc_hit;
    ctl_o.step   = stepping;
    ctl_o.fixup  = (state_q == S_FIX);
    ctl_o.is_div = is_div_q;
  end

  assign done_o = done_q;

endmodule

//--- design/mdu_datapath.sv
module mdu_datapath (
  input  logic               clk,
  input  logic               rst_n,
  input  mdu_pkg::mdu_ctl_t  ctl_i,
  input  mdu_pkg::mdu_prep_t prep_i,
  output mdu_pkg::mdu_resp_t resp_o
);
  import mdu_pkg::*;

  logic [XLEN-1:0] a_q;    // multiplicand or dividend then quotient
  logic [XLEN-1:0] b_q;    // multiplier or divisor
  logic [XLEN-1:0] acc_q;  // product or partial remainder
  logic            q_neg_q;
  logic            r_neg_q;
  logic            is_rem_q;
  mdu_resp_t       resp_q;

  logic [XLEN:0]   add_a;
  logic [XLEN:0]   add_b;
  logic            add_sub;
  logic [XLEN:0]   add_sum;
  logic            borrow;
  logic [XLEN-1:0] fix_sel;
  logic            fix_neg;
  logic [XLEN-1:0] exc_rem;

  assign fix_sel = is_rem_q ? acc_q : a_q;
  assign fix_neg = is_rem_q ? r_neg_q : q_neg_q;

  // input select for the one adder/subtractor
  always_comb begin
    add_a   = '0;
    add_b   = '0;
    add_sub = 1'b0;
    if (ctl_i.exc) begin
      add_b   = {1'b0, prep_i.a_mag};  // rebuild signed rs1
      add_sub = 1'b1;
    end else if (ctl_i.fixup) begin
      add_b   = {1'b0, fix_sel};
      add_sub = 1'b1;
    end else if (ctl_i.is_div) begin
      add_a   = {acc_q, a_q[XLEN-1]};  // remainder shifted with next dividend bit
      add_b   = {1'b0, b_q};
      add_sub = 1'b1;
    end else begin
      add_a   = {1'b0, acc_q};
      add_b   = {1'b0, a_q};
    end
  end

  assign add_sum = add_a + (add_b ^ {(XLEN+1){add_sub}}) + {{XLEN{1'b0}}, add_sub};
  assign borrow  = add_sum[XLEN];  // shifted remainder below divisor

  assign exc_rem = prep_i.neg_r ? add_sum[XLEN-1:0] : prep_i.a_mag;

  // iteration registers
  always_ff @(posedge clk) begin
    if (ctl_i.load) begin
      a_q      <= prep_i.a_mag;
      b_q      <= prep_i.b_mag;
      acc_q    <= '0;
      q_neg_q  <= prep_i.neg_q;
      r_neg_q  <= prep_i.neg_r;
      is_rem_q <= prep_i.is_rem;
    end else if (ctl_i.step) begin
      if (ctl_i.is_div) begin
        acc_q <= borrow ? add_a[XLEN-1:0] : add_sum[XLEN-1:0];  // restore on borrow
        a_q   <= {a_q[XLEN-2:0], ~borrow};
      end else begin
        if (b_q[0]) begin
          acc_q <= add_sum[XLEN-1:0];
        end
        a_q <= a_q << 1;
        b_q <= b_q >> 1;
      end
    end
  end

  // result register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_q <= '0;
    end else if (ctl_i.exc) begin
      resp_q.div_by_zero  <= prep_i.div_by_zero;
      resp_q.div_overflow <= prep_i.div_overflow;
      if (prep_i.is_rem) begin
        resp_q.result <= prep_i.div_by_zero ? exc_rem : '0;
      end else begin
        // overflow quotient is the dividend itself
        resp_q.result <= prep_i.div_by_zero ? '1 : prep_i.a_mag;
      end
    end else if (ctl_i.fixup) begin
      resp_q.div_by_zero  <= 1'b0;
      resp_q.div_overflow <= 1'b0;
      if (ctl_i.is_div) begin
        resp_q.result <= fix_neg ? add_sum[XLEN-1:0] : fix_sel;
      end else begin
        resp_q.result <= acc_q;  // product needs no sign fix
      end
    end
  end

  assign resp_o = resp_q;

endmodule

//--- design/mdu_operand_prep.sv
module mdu_operand_prep (
  input  mdu_pkg::mdu_req_t  req_i,
  output mdu_pkg::mdu_prep_t prep_o
);
  import mdu_pkg::*;

  logic is_div;
  logic is_rem;
  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic rs2_zero;
  logic overflow;
  logic by_zero;

  // opcode decode
  always_comb begin
    is_div    = 1'b0;
    is_rem    = 1'b0;
    is_signed = 1'b0;
    case (req_i.op)
      OP_DIV: begin
        is_div    = 1'b1;
        is_signed = 1'b1;
      end
      OP_DIVU: begin
        is_div = 1'b1;
      end
      OP_REM: begin
        is_div    = 1'b1;
        is_rem    = 1'b1;
        is_signed = 1'b1;
      end
      OP_REMU: begin
        is_div = 1'b1;
        is_rem = 1'b1;
      end
      default: ;  // mul and the mulh codes
    endcase
  end

  assign a_neg    = is_signed & req_i.rs1[XLEN-1];
  assign b_neg    = is_signed & req_i.rs2[XLEN-1];
  assign rs2_zero = (req_i.rs2 == '0);
  assign by_zero  = is_div & rs2_zero;
  assign overflow = is_signed & (req_i.rs1 == INT_MIN) & (req_i.rs2 == '1);

  always_comb begin
    prep_o.is_div       = is_div;
    prep_o.is_rem       = is_rem;
    // unsigned ops and mul keep the raw operands
    prep_o.a_mag        = a_neg ? -req_i.rs1 : req_i.rs1;
    prep_o.b_mag        = b_neg ? -req_i.rs2 : req_i.rs2;
    prep_o.neg_q        = (a_neg ^ b_neg) & ~(by_zero | overflow);
    prep_o.neg_r        = a_neg;  // remainder follows the dividend
    prep_o.div_by_zero  = by_zero;
    prep_o.div_overflow = overflow;
  end

endmodule

//--- design/mdu_pkg.sv
package mdu_pkg;

  localparam int XLEN  = 32;
  localparam int CNT_W = 6;   // holds 0 up to XLEN

  // most negative operand for the overflow check
  localparam logic [XLEN-1:0] INT_MIN = {1'b1, {(XLEN-1){1'b0}}};

  // funct3 of the M extension
  typedef enum logic [2:0] {
    OP_MUL  = 3'b000,
    OP_DIV  = 3'b100,
    OP_DIVU = 3'b101,
    OP_REM  = 3'b110,
    OP_REMU = 3'b111
  } mdu_op_e;

  typedef enum logic [2:0] {
    S_IDLE = 3'd0,
    S_EXC  = 3'd1,
    S_LOAD = 3'd2,
    S_MUL  = 3'd3,
    S_DIV  = 3'd4,
    S_FIX  = 3'd5,
    S_DONE = 3'd6
  } mdu_state_e;

  typedef struct packed {
    mdu_op_e         op;
    logic [XLEN-1:0] rs1;  // dividend or multiplicand
    logic [XLEN-1:0] rs2;  // divisor or multiplier
  } mdu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            div_by_zero;
    logic            div_overflow;
  } mdu_resp_t;

  typedef struct packed {
    logic            is_div;
    logic            is_rem;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic            neg_q;
    logic            neg_r;
    logic            div_by_zero;
    logic            div_overflow;
  } mdu_prep_t;

  typedef struct packed {
    logic load;
    logic step;
    logic fixup;
    logic exc;
    logic is_div;
  } mdu_ctl_t;

endpackage

//--- design/mdu_top.sv
module mdu_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  mdu_pkg::mdu_req_t  req_i,
  output logic               done_o,
  output mdu_pkg::mdu_resp_t resp_o
);
  import mdu_pkg::*;

  mdu_prep_t prep;
  mdu_ctl_t  ctl;

  // sign handling and exception detect
  mdu_operand_prep mdu_operand_prep_i (
    .req_i  (req_i),
    .prep_o (prep)
  );

  mdu_ctrl mdu_ctrl_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (valid_i),
    .prep_i  (prep),
    .ctl_o   (ctl),
    .done_o  (done_o)
  );

  mdu_datapath mdu_datapath_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctl_i  (ctl),
    .prep_i (prep),
    .resp_o (resp_o)
  );

endmodule

//--- verif/mdu_assert.sv
module mdu_assert (
  input logic                clk,
  input logic                rst_n,
  input logic                valid_i,
  input mdu_pkg::mdu_state_e state_i,
  input mdu_pkg::mdu_ctl_t   ctl_i,
  input logic                done_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import mdu_pkg::*;

  done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i)
    else $error("done_o stayed high for more than one cycle");

  // a new run starts only from a strobe
  idle_exit_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == S_IDLE && !valid_i) |=> (state_i == S_IDLE))
    else $error("controller left idle without valid_i");

  // iteration window is XLEN steps, then fix-up
  step_state_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ctl_i.step) |-> ##XLEN (!ctl_i.step && state_i == S_FIX))
    else $error("step window did not end in fix-up after XLEN cycles");

endmodule

bind mdu_ctrl mdu_assert mdu_assert_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid_i (valid_i),
  .state_i (state_q),
  .ctl_i   (ctl_o),
  .done_i  (done_o)
);

//--- verif/mdu_tb.sv
module mdu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mdu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_DIR      = 21;
  localparam int N_RAND     = 40;
  localparam int N_ROWS     = N_DIR + N_RAND;
  localparam int ROW_CYCLES = 40;  // budget per row for the watchdog
  localparam int MAX_WAIT   = 60;  // per-request limit on waiting for done_o

  typedef struct packed {
    logic [2:0]      op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] result;
    logic            div_by_zero;
    logic            div_overflow;
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      valid;
  mdu_req_t  req;
  logic      done;
  mdu_resp_t resp;

  row_t   rows [N_ROWS];
  int     n_rows;
  integer seed = 32'h5c3a50ec;

  mdu_top mdu_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (valid),
    .req_i   (req),
    .done_o  (done),
    .resp_o  (resp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want,
                          input string what);
    if (got !== want) begin
      $display("FAIL at %0d ns: %s got %h expected %h", $time, what, got, want);
      $display("sim failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // expected values straight from the M extension rules
  function automatic mdu_resp_t ref_model(input logic [2:0] op, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
    mdu_resp_t              r;
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic                   ovf;
    r   = '0;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      OP_DIV, OP_REM: begin
        if (b == '0) begin
          r.result      = (op == OP_DIV) ? 32'hffff_ffff : a;
          r.div_by_zero = 1'b1;
        end else if (ovf) begin
          r.result       = (op == OP_DIV) ? a : 32'h0;
          r.div_overflow = 1'b1;
        end else begin
          r.result = (op == OP_DIV) ? sa / sb : sa % sb;  // truncates toward zero
        end
      end
      OP_DIVU, OP_REMU: begin
        if (b == '0) begin
          r.result      = (op == OP_DIVU) ? 32'hffff_ffff : a;
          r.div_by_zero = 1'b1;
        end else begin
          r.result = (op == OP_DIVU) ? a / b : a % b;
        end
      end
      default: r.result = a * b;  // low word only
    endcase
    return r;
  endfunction

  task automatic add_row(input logic [2:0] op, input logic [XLEN-1:0] rs1,
                         input logic [XLEN-1:0] rs2, input logic [XLEN-1:0] result,
                         input logic dz, input logic ovf);
    rows[n_rows] = '{op, rs1, rs2, result, dz, ovf};
    n_rows++;
  endtask

  task automatic build_directed_rows();
    add_row(OP_MUL,  32'd7,         32'd6,         32'h0000_002a, 1'b0, 1'b0);
    add_row(OP_MUL,  32'hffff_ffff, 32'd5,         32'hffff_fffb, 1'b0, 1'b0);
    add_row(OP_MUL,  32'h8000_0000, 32'd2,         32'h0000_0000, 1'b0, 1'b0);
    add_row(OP_MUL,  32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0);
    add_row(3'b011,  32'd3,         32'hffff_fffe, 32'hffff_fffa, 1'b0, 1'b0);  // mulhu code
    add_row(OP_DIVU, 32'd100,       32'd7,         32'h0000_000e, 1'b0, 1'b0);
    add_row(OP_REMU, 32'd100,       32'd7,         32'h0000_0002, 1'b0, 1'b0);
    add_row(OP_DIVU, 32'hffff_ffff, 32'd2,         32'h7fff_ffff, 1'b0, 1'b0);
    add_row(OP_DIV,  32'hffff_fff9, 32'd2,         32'hffff_fffd, 1'b0, 1'b0);
    add_row(OP_REM,  32'hffff_fff9, 32'd2,         32'hffff_ffff, 1'b0, 1'b0);
    add_row(OP_DIV,  32'd7,         32'hffff_fffe, 32'hffff_fffd, 1'b0, 1'b0);
    add_row(OP_REM,  32'd7,         32'hffff_fffe, 32'h0000_0001, 1'b0, 1'b0);
    add_row(OP_DIV,  32'h8000_0000, 32'd2,         32'hc000_0000, 1'b0, 1'b0);
    // divide by zero
    add_row(OP_DIV,  32'h0000_1234, 32'd0,         32'hffff_ffff, 1'b1, 1'b0);
    add_row(OP_REM,  32'hffff_ff00, 32'd0,         32'hffff_ff00, 1'b1, 1'b0);
    add_row(OP_DIVU, 32'd5,         32'd0,         32'hffff_ffff, 1'b1, 1'b0);
    add_row(OP_REMU, 32'h8000_0001, 32'd0,         32'h8000_0001, 1'b1, 1'b0);
    // signed overflow, and the same operands unsigned
    add_row(OP_DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0, 1'b1);
    add_row(OP_REM,  32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 1'b0, 1'b1);
    add_row(OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 1'b0, 1'b0);
    add_row(OP_REMU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0, 1'b0);
  endtask

  task automatic build_random_rows();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [2:0]      op;
    mdu_resp_t       want;
    int              sel;
    for (int i = 0; i < N_RAND; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      sel = int'($unsigned($random(seed)) % 5);
      if (i % 3 == 1) begin
        b = b >> b[4:0];  // smaller divisors now and then
      end
      case (sel)
        0:       op = OP_MUL;
        1:       op = OP_DIV;
        2:       op = OP_DIVU;
        3:       op = OP_REM;
        default: op = OP_REMU;
      endcase
      want = ref_model(op, a, b);
      add_row(op, a, b, want.result, want.div_by_zero, want.div_overflow);
    end
  endtask

  task automatic run_row(input row_t row, input int idx);
    int cyc;
    int want_cyc;
    cyc      = 0;
    want_cyc = (row.div_by_zero | row.div_overflow) ? 1 : 35;
    @(posedge clk);
    req.op  <= mdu_op_e'(row.op);
    req.rs1 <= row.rs1;
    req.rs2 <= row.rs2;
    valid   <= 1'b1;
    @(posedge clk);  // accepting edge
    valid   <= 1'b0;
    req.rs1 <= ~row.rs1;  // operands must already be captured
    req.rs2 <= '0;
    @(negedge clk);
    while (!done) begin
      if (cyc > MAX_WAIT) begin
        $display("timeout: no done_o within %0d cycles for row %0d", MAX_WAIT, idx);
        $display("sim failed");
        $fatal(1, "request never completed");
      end
      @(posedge clk);
      cyc++;
      if (cyc == 10) begin
        valid   <= 1'b1;  // stray strobe while busy
        req.op  <= OP_REMU;
        req.rs2 <= 32'd3;
      end else if (cyc == 11) begin
        valid <= 1'b0;
      end
      @(negedge clk);
    end
    check_eq(cyc, want_cyc, $sformatf("row %0d latency", idx));
    check_eq(resp.result, row.result, $sformatf("row %0d result", idx));
    check_eq(XLEN'(resp.div_by_zero), XLEN'(row.div_by_zero),
             $sformatf("row %0d div_by_zero", idx));
    check_eq(XLEN'(resp.div_overflow), XLEN'(row.div_overflow),
             $sformatf("row %0d div_overflow", idx));
    @(negedge clk);
    check_eq(XLEN'(done), '0, $sformatf("row %0d done_o width", idx));
    check_eq(resp.result, row.result, $sformatf("row %0d result hold", idx));
  endtask

  initial begin
    rst_n  = 1'b0;
    valid  = 1'b0;
    req    = '0;
    n_rows = 0;
    build_directed_rows();
    build_random_rows();
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq(XLEN'(done), '0, "done_o after reset");
    check_eq(resp.result, '0, "result after reset");
    check_eq(XLEN'({resp.div_by_zero, resp.div_overflow}), '0, "flags after reset");
    for (int i = 0; i < N_ROWS; i++) begin
      run_row(rows[i], i);
    end
    $display("sim passed");
    $finish;
  end

  // whole-run limit
  initial begin
    repeat (RST_CYCLES + N_ROWS * ROW_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles",
             RST_CYCLES + N_ROWS * ROW_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule
